// File: design/shiftPkg.sv
// Shift unit shared definitions
package shiftPkg;

  // ==================================================
  // widths
  // ==================================================

  // operand and result width of the unit
  localparam int dataWidth = 128;
  // full instruction word as issued by the core
  localparam int instrWidth = 40;
  // shift amount covers 0 to 127
  localparam int amountWidth = 7;
  // opcode and function fields are both six bits wide
  localparam int fieldWidth = 6;

  // ==================================================
  // instruction fields
  // ==================================================

  // opcode sits in the low bits of the instruction word
  localparam int opcodeLsb = 0;
  localparam int opcodeMsb = opcodeLsb + fieldWidth - 1;
  // function field sits in the top bits of the instruction word
  localparam int funct6Lsb = instrWidth - fieldWidth;
  localparam int funct6Msb = instrWidth - 1;

  // the two register-register opcodes that carry shift functions
  localparam logic [fieldWidth-1:0] opR2 = 6'h02;
  localparam logic [fieldWidth-1:0] opR2S = 6'h03;

  // register forms of the shift functions
  localparam logic [fieldWidth-1:0] fnShl = 6'h10;
  localparam logic [fieldWidth-1:0] fnAsl = 6'h11;
  localparam logic [fieldWidth-1:0] fnShr = 6'h12;
  localparam logic [fieldWidth-1:0] fnAsr = 6'h13;
  localparam logic [fieldWidth-1:0] fnRol = 6'h14;
  localparam logic [fieldWidth-1:0] fnRor = 6'h15;

  // immediate forms, the amount still comes from the amount operand
  localparam logic [fieldWidth-1:0] fnShli = 6'h18;
  localparam logic [fieldWidth-1:0] fnAsli = 6'h19;
  localparam logic [fieldWidth-1:0] fnShri = 6'h1A;
  localparam logic [fieldWidth-1:0] fnAsri = 6'h1B;
  localparam logic [fieldWidth-1:0] fnRoli = 6'h1C;
  localparam logic [fieldWidth-1:0] fnRori = 6'h1D;

  // marker pattern returned by rotates when the rotate hardware is left out
  localparam logic [dataWidth-1:0] rotateFill = {8{16'hDEAD}};

  // ==================================================
  // stage types
  // ==================================================

  // arithmetic left gives the same bits as logical left, so both map to opShl
  typedef enum logic [2:0] {
    opShl,
    opShr,
    opAsr,
    opRol,
    opRor,
    opNone
  } shiftOpE;

  // request as presented by the host
  typedef struct packed {
    logic [instrWidth-1:0] instr;
    logic [dataWidth-1:0] a;
    logic [amountWidth-1:0] amount;
  } shiftReqT;

  // decoded operation handed from decode to execute
  typedef struct packed {
    shiftOpE op;
    logic [dataWidth-1:0] a;
    logic [amountWidth-1:0] amount;
    logic illegal;
  } decodedOpT;

  // result with its flags, from execute onwards
  typedef struct packed {
    logic [dataWidth-1:0] res;
    logic ov;
    logic illegal;
  } shiftResT;

endpackage

// File: design/shiftDecode.sv
// Shift instruction decode stage
module shiftDecode (
  input  logic                clk,
  input  logic                rstN,
  input  logic                req,
  input  shiftPkg::shiftReqT  request,
  input  logic                busy,
  output logic                decValid,
  output shiftPkg::decodedOpT decOp
);

  // instruction fields pulled out of the request
  logic [shiftPkg::fieldWidth-1:0] opcode;
  logic [shiftPkg::fieldWidth-1:0] funct6;
  // classification of the current request
  shiftPkg::shiftOpE opNext;
  logic illegalNext;
  // a new request is taken only when nothing is in flight
  logic accept;

  assign opcode = request.instr[shiftPkg::opcodeMsb:shiftPkg::opcodeLsb];
  assign funct6 = request.instr[shiftPkg::funct6Msb:shiftPkg::funct6Lsb];

  // decValid covers the single cycle before result raises busy
  assign accept = req && !busy && !decValid;

  // ==================================================
  // opcode and function classification
  // ==================================================
  always_comb begin
    opNext = shiftPkg::opNone;
    illegalNext = 1'b1;
    if ((opcode == shiftPkg::opR2) || (opcode == shiftPkg::opR2S)) begin
      illegalNext = 1'b0;
      case (funct6)
        // register and immediate forms decode the same way
        shiftPkg::fnShl, shiftPkg::fnShli,
        shiftPkg::fnAsl, shiftPkg::fnAsli: opNext = shiftPkg::opShl;
        shiftPkg::fnShr, shiftPkg::fnShri: opNext = shiftPkg::opShr;
        shiftPkg::fnAsr, shiftPkg::fnAsri: opNext = shiftPkg::opAsr;
        shiftPkg::fnRol, shiftPkg::fnRoli: opNext = shiftPkg::opRol;
        shiftPkg::fnRor, shiftPkg::fnRori: opNext = shiftPkg::opRor;
        default: begin
          // unknown function under a shift opcode
          opNext = shiftPkg::opNone;
          illegalNext = 1'b1;
        end
      endcase
    end
  end

  // ==================================================
  // request capture
  // ==================================================

  // one cycle pulse per accepted request
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else begin
      decValid <= accept;
    end
  end

  // operands are held until the next accept, execute reads them one edge later
  always_ff @(posedge clk) begin
    if (accept) begin
      decOp.op <= opNext;
      decOp.a <= request.a;
      decOp.amount <= request.amount;
      decOp.illegal <= illegalNext;
    end
  end

endmodule

// File: design/shift128.sv
// 128-bit shift and rotate execute stage
module shift128 #(
  parameter bit rotateEn = 1'b1
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                decValid,
  input  shiftPkg::decodedOpT decOp,
  output logic                exValid,
  output shiftPkg::shiftResT  exRes
);

  // double width products of the operand by the amount
  logic [2*shiftPkg::dataWidth-1:0] shlProd;
  logic [2*shiftPkg::dataWidth-1:0] shrProd;
  // ones in the vacated top bits of an arithmetic right shift
  logic [shiftPkg::dataWidth-1:0] signFill;
  logic signBit;
  // combinational result ahead of the stage register
  logic [shiftPkg::dataWidth-1:0] resNext;
  logic ovNext;

  assign signBit = decOp.a[shiftPkg::dataWidth-1];

  // ==================================================
  // shift products
  // ==================================================

  // left product, low half is the shifted value and high half is what fell out
  assign shlProd = {{shiftPkg::dataWidth{1'b0}}, decOp.a} << decOp.amount;

  // right product, high half is the shifted value and low half is what fell out
  assign shrProd = {decOp.a, {shiftPkg::dataWidth{1'b0}}} >> decOp.amount;

  // mask of the top amount bits
  assign signFill = ~({shiftPkg::dataWidth{1'b1}} >> decOp.amount);

  // ==================================================
  // operation select
  // ==================================================
  always_comb begin
    resNext = '0;
    case (decOp.op)
      shiftPkg::opShl: begin
        resNext = shlProd[shiftPkg::dataWidth-1:0];
      end
      shiftPkg::opShr: begin
        resNext = shrProd[2*shiftPkg::dataWidth-1:shiftPkg::dataWidth];
      end
      shiftPkg::opAsr: begin
        // a negative operand brings ones in from the top
        if (signBit) begin
          resNext = shrProd[2*shiftPkg::dataWidth-1:shiftPkg::dataWidth] | signFill;
        end else begin
          resNext = shrProd[2*shiftPkg::dataWidth-1:shiftPkg::dataWidth];
        end
      end
      shiftPkg::opRol: begin
        // the bits that fell out of the top wrap back into the bottom
        resNext = rotateEn
                  ? (shlProd[shiftPkg::dataWidth-1:0]
                     | shlProd[2*shiftPkg::dataWidth-1:shiftPkg::dataWidth])
                  : shiftPkg::rotateFill;
      end
      shiftPkg::opRor: begin
        resNext = rotateEn
                  ? (shrProd[shiftPkg::dataWidth-1:0]
                     | shrProd[2*shiftPkg::dataWidth-1:shiftPkg::dataWidth])
                  : shiftPkg::rotateFill;
      end
      default: begin
        // opNone, illegal instructions return zero
        resNext = '0;
      end
    endcase
  end

  // overflow when the bits pushed out on the left are not all copies of the sign
  assign ovNext = !decOp.illegal
                  && (shlProd[2*shiftPkg::dataWidth-1:shiftPkg::dataWidth]
                      != {shiftPkg::dataWidth{signBit}});

  // ==================================================
  // stage register
  // ==================================================

  // exValid follows decValid by one edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
    end else begin
      exValid <= decValid;
    end
  end

  always_ff @(posedge clk) begin
    if (decValid) begin
      exRes.res <= resNext;
      exRes.ov <= ovNext;
      exRes.illegal <= decOp.illegal;
    end
  end

endmodule

// File: design/shiftResult.sv
// Shift result and handshake stage
module shiftResult (
  input  logic               clk,
  input  logic               rstN,
  input  logic               req,
  input  logic               exValid,
  input  shiftPkg::shiftResT exRes,
  input  logic               decValid,
  output logic               ack,
  output logic               busy,
  output shiftPkg::shiftResT result
);

  // idle waits for an accept, active lasts until the host releases req
  typedef enum logic {
    stIdle,
    stActive
  } hsStateE;

  hsStateE state;

  // decode stays off the request while the unit is active
  assign busy = (state == stActive);

  // ==================================================
  // handshake machine
  // ==================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
      ack <= 1'b0;
      result <= '0;
    end else begin
      case (state)
        stIdle: begin
          // decode has taken a request this cycle
          if (decValid) begin
            state <= stActive;
          end
        end
        stActive: begin
          if (ack && !req) begin
            // host has seen ack and dropped req, ack and busy fall together
            ack <= 1'b0;
            state <= stIdle;
          end else if (exValid) begin
            // result is held here until the next ack rise
            result <= exRes;
            ack <= 1'b1;
          end
        end
        default: begin
          state <= stIdle;
          ack <= 1'b0;
        end
      endcase
    end
  end

  // while req is held high after ack nothing above changes, so result and ack
  // stay put for the whole back-pressure period

endmodule

// File: design/shiftUnit.sv
// 128-bit shift unit top
module shiftUnit #(
  parameter bit rotateEn = 1'b1
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               req,
  input  shiftPkg::shiftReqT request,
  output logic               ack,
  output shiftPkg::shiftResT result
);

  // busy level from result back to decode
  logic busy;
  // decode to execute
  logic decValid;
  shiftPkg::decodedOpT decOp;
  // execute to result
  logic exValid;
  shiftPkg::shiftResT exRes;

  // ==================================================
  // stage instances
  // ==================================================

  // stage one takes the request and classifies it
  shiftDecode decode_i (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .request  (request),
    .busy     (busy),
    .decValid (decValid),
    .decOp    (decOp)
  );

  // stage two computes and registers the shift
  shift128 #(
    .rotateEn (rotateEn)
  ) execute_i (
    .clk      (clk),
    .rstN     (rstN),
    .decValid (decValid),
    .decOp    (decOp),
    .exValid  (exValid),
    .exRes    (exRes)
  );

  // stage three owns ack and the release on req low
  shiftResult result_i (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .exValid  (exValid),
    .exRes    (exRes),
    .decValid (decValid),
    .ack      (ack),
    .busy     (busy),
    .result   (result)
  );

endmodule

// File: sim/shiftChecker.sv
// Shift unit result checker
module shiftChecker (
  input  logic               clk,
  input  logic               rstN,
  input  logic               req,
  input  logic               ack,
  input  shiftPkg::shiftResT result,
  input  shiftPkg::shiftResT expected,
  input  int                 testNum,
  output int                 passCount,
  output int                 failCount
);
  timeunit 1ns;
  timeprecision 100ps;

  // port values seen at the previous rising edge
  bit ackPrev = 1'b0;
  bit reqPrev = 1'b0;
  // result captured at the ack rise, it must not move while ack is high
  shiftPkg::shiftResT held = '0;
  // errors seen during the current test
  int testErrors = 0;
  // edges counted since req was first seen high
  int latency = 0;
  bit timing = 1'b0;
  bit resetChecked = 1'b0;

  task automatic reportMismatch(input string name, input logic [127:0] expVal,
                                input logic [127:0] gotVal);
    $display("Mismatch %s in test %0d: expected 0x%h, got 0x%h",
             name, testNum, expVal, gotVal);
    testErrors++;
  endtask

  // ==================================================
  // sampling at every rising edge
  // ==================================================
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ackPrev = 1'b0;
      reqPrev = 1'b0;
      timing = 1'b0;
      resetChecked = 1'b0;
      passCount = 0;
      failCount = 0;
    end else begin
      // the first edge out of reset must see ack low
      if (!resetChecked) begin
        resetChecked = 1'b1;
        if (ack) begin
          $display("ack was high right after reset");
          failCount++;
        end
      end
      // a new request starts the latency count and the error tally
      if (req && !reqPrev) begin
        timing = 1'b1;
        latency = 0;
        testErrors = 0;
      end else if (timing) begin
        latency++;
      end
      if (ack && !ackPrev) begin
        timing = 1'b0;
        if (result.res !== expected.res) reportMismatch("result.res", expected.res, result.res);
        if (result.ov !== expected.ov) reportMismatch("result.ov", expected.ov, result.ov);
        if (result.illegal !== expected.illegal) begin
          reportMismatch("result.illegal", expected.illegal, result.illegal);
        end
        if (latency != 3) reportMismatch("ack latency", 128'd3, latency);
        held = result;
      end else if (ack && ackPrev) begin
        // back-pressure, result has to stay where it was
        if (result.res !== held.res) reportMismatch("held result.res", held.res, result.res);
        if ({result.ov, result.illegal} !== {held.ov, held.illegal}) begin
          reportMismatch("held result flags", {held.ov, held.illegal},
                         {result.ov, result.illegal});
        end
      end
      if (ackPrev && reqPrev && !ack) begin
        $display("ack fell in test %0d while req was still high", testNum);
        testErrors++;
      end
      // the test is over once ack drops
      if (ackPrev && !ack) begin
        if (testErrors == 0) begin
          $display("test %0d passed", testNum);
          passCount++;
        end else begin
          $display("test %0d failed with %0d errors", testNum, testErrors);
          failCount++;
        end
      end
      ackPrev = ack;
      reqPrev = req;
    end
  end

endmodule

// File: sim/tbShiftUnit.sv
// Shift unit testbench
module tbShiftUnit;
  timeunit 1ns;
  timeprecision 100ps;

  // one line of the vector file
  typedef struct packed {
    logic [shiftPkg::instrWidth-1:0] instr;
    logic [shiftPkg::dataWidth-1:0] a;
    logic [shiftPkg::amountWidth-1:0] amount;
    shiftPkg::shiftResT expected;
  } vectorT;

  logic clk = 1'b0;
  logic rstN = 1'b0;
  logic req = 1'b0;
  shiftPkg::shiftReqT request = '0;
  logic ack;
  shiftPkg::shiftResT result;
  shiftPkg::shiftResT expected = '0;
  int testNum = 0;
  int passCount;
  int failCount;
  vectorT vectors[$];
  bit loaded;
  bit testOk;
  bit timedOut = 1'b0;

  // 4 ns period
  always #2 clk = ~clk;

  shiftUnit dut_i (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .request (request),
    .ack     (ack),
    .result  (result)
  );

  shiftChecker checker_i (
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .ack       (ack),
    .result    (result),
    .expected  (expected),
    .testNum   (testNum),
    .passCount (passCount),
    .failCount (failCount)
  );

  // ==================================================
  // vector file
  // ==================================================
  task automatic loadVectors(output bit ok);
    int fd;
    int n;
    string line;
    logic [39:0] instr;
    logic [127:0] a;
    logic [6:0] amount;
    logic [127:0] res;
    logic ov;
    logic illegal;
    vectorT v;
    ok = 1'b0;
    fd = $fopen("sim/shiftStimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file sim/shiftStimulus.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h", instr, a, amount, res, ov, illegal);
      if (n == 6) begin
        v.instr = instr;
        v.a = a;
        v.amount = amount;
        v.expected.res = res;
        v.expected.ov = ov;
        v.expected.illegal = illegal;
        vectors.push_back(v);
      end
    end
    $fclose(fd);
    ok = (vectors.size() > 0);
    if (!ok) $display("the vector file holds no vectors");
  endtask

  // ==================================================
  // host side of the four-phase handshake
  // ==================================================
  task automatic waitForAck(input logic level, output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < 20; cycles++) begin
      @(posedge clk);
      if (ack === level) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  // called at a rising edge, returns at the edge where ack is seen low
  task automatic runTest(input vectorT v, output bit ok);
    request.instr <= v.instr;
    request.a <= v.a;
    request.amount <= v.amount;
    expected <= v.expected;
    req <= 1'b1;
    waitForAck(1'b1, ok);
    if (!ok) begin
      $display("test %0d: ack did not rise within 20 cycles", testNum);
      return;
    end
    // back-pressure, req stays high for 5 more cycles
    repeat (5) @(posedge clk);
    req <= 1'b0;
    waitForAck(1'b0, ok);
    if (!ok) $display("test %0d: ack did not fall within 20 cycles", testNum);
  endtask

  initial begin
    loadVectors(loaded);
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    if (loaded) begin
      foreach (vectors[i]) begin
        testNum <= i + 1;
        runTest(vectors[i], testOk);
        if (!testOk) begin
          timedOut = 1'b1;
          break;
        end
      end
    end
    // let the checker log the last ack fall
    repeat (3) @(posedge clk);
    $display("tests %0d, passed %0d, failed %0d", vectors.size(), passCount, failCount);
    if (loaded && !timedOut && failCount == 0 && passCount == vectors.size()) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/shiftStimulus.txt
# columns: instr(40b) operand(128b) amount(7b) expResult(128b) expOv expIllegal, all hex
# instr holds funct6 in bits 39:34 and the opcode in bits 5:0
4000000002 0123456789abcdeffedcba9876543210 00 0123456789abcdeffedcba9876543210 0 0
6000000002 0123456789abcdeffedcba9876543210 01 02468acf13579bdffdb97530eca86420 0 0
4000000003 0123456789abcdeffedcba9876543210 40 fedcba98765432100000000000000000 1 0
6000000003 0123456789abcdeffedcba9876543210 7f 00000000000000000000000000000000 1 0
4800000002 0123456789abcdeffedcba9876543210 00 0123456789abcdeffedcba9876543210 0 0
6800000003 0123456789abcdeffedcba9876543210 01 0091a2b3c4d5e6f7ff6e5d4c3b2a1908 0 0
4800000002 0123456789abcdeffedcba9876543210 40 00000000000000000123456789abcdef 1 0
6800000002 0123456789abcdeffedcba9876543210 7f 00000000000000000000000000000000 1 0
4c00000002 80000000000000000000000000000001 04 f8000000000000000000000000000000 1 0
6c00000002 80000000000000000000000000000001 7f ffffffffffffffffffffffffffffffff 1 0
6c00000003 0123456789abcdeffedcba9876543210 08 000123456789abcdeffedcba98765432 1 0
4400000002 0123456789abcdeffedcba9876543210 01 02468acf13579bdffdb97530eca86420 0 0
6400000002 0123456789abcdeffedcba9876543210 40 fedcba98765432100000000000000000 1 0
5000000002 0123456789abcdeffedcba9876543210 00 0123456789abcdeffedcba9876543210 0 0
5000000003 0123456789abcdeffedcba9876543210 04 123456789abcdeffedcba98765432100 0 0
7400000002 0123456789abcdeffedcba9876543210 08 100123456789abcdeffedcba98765432 1 0
7000000002 0123456789abcdeffedcba9876543210 40 fedcba98765432100123456789abcdef 1 0
5400000002 0123456789abcdeffedcba9876543210 00 0123456789abcdeffedcba9876543210 0 0
4000000002 00000000000000000000000000000005 03 00000000000000000000000000000028 0 0
4000000002 40000000000000000000000000000001 02 00000000000000000000000000000004 1 0
fc00000002 0123456789abcdeffedcba9876543210 04 00000000000000000000000000000000 0 1
4000000005 0123456789abcdeffedcba9876543210 04 00000000000000000000000000000000 0 1

// File: tb.f
design/shiftPkg.sv
design/shiftDecode.sv
design/shift128.sv
design/shiftResult.sv
design/shiftUnit.sv
sim/shiftChecker.sv
sim/tbShiftUnit.sv

// File: Makefile
# Verilator build and run for the shift unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and fail if the log reports failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f tb.f --top-module tbShiftUnit -o VtbShiftUnit
	./obj_dir/VtbShiftUnit > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
